//--- Bender.yml
package:
  name: wb_stage

sources:
  - wb_pkg.sv
  - lsu_ctrl.sv
  - load_align.sv
  - store_align.sv
  - wb_stage.sv
  - target: test
    files:
      - tb_data_mem.sv
      - tb_wb_stage.sv

//--- load_align.sv
// ==============================
// Load data assembly, shift and sign/zero extension
// ==============================

`timescale 1ns/100ps

module load_align
    import wb_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  lsu_req_t        req,
    input  logic            capture,
    input  logic            beat_sel,
    input  logic [XLEN-1:0] data_rd_data,
    output logic [XLEN-1:0] load_data
);

    logic [XLEN-1:0]   first_word;
    logic [2*XLEN-1:0] pair;
    logic [2*XLEN-1:0] shifted;
    logic [XLEN-1:0]   extended;
    logic              last_beat;
    logic              sign;

    assign last_beat = capture & (beat_sel | ~req.split);

    // Low word of a split access
    always_ff @(posedge clk) begin
        if (capture && !beat_sel) first_word <= data_rd_data;
    end

    always_comb begin
        if (req.split) begin
            pair = {data_rd_data, first_word};
        end else begin
            pair = {{XLEN{1'b0}}, data_rd_data};
        end
        shifted = pair >> {req.offset, 3'b000};

        case (req.size)
            BYTE: begin
                sign     = ~req.is_unsigned & shifted[7];
                extended = {{(XLEN-8){sign}}, shifted[7:0]};
            end
            HALF: begin
                sign     = ~req.is_unsigned & shifted[15];
                extended = {{(XLEN-16){sign}}, shifted[15:0]};
            end
            default: begin
                sign     = 1'b0;
                extended = shifted[XLEN-1:0];
            end
        endcase
    end

    // Result held for the write-back cycle after the last grant
    always_ff @(posedge clk) begin
        if (reset) begin
            load_data <= '0;
        end else if (last_beat) begin
            load_data <= extended;
        end
    end

endmodule

//--- lsu_ctrl.sv
// ==============================
// Load/store FSM that sequences one or two aligned beats
// ==============================

`timescale 1ns/100ps

module lsu_ctrl
    import wb_pkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  pipe_exwb_t      op,
    input  logic            data_gnt,
    output lsu_req_t        req,
    output logic [XLEN-1:0] data_addr,
    output logic            data_rd_req,
    output logic            data_wr_req,
    output logic            beat_sel,
    output logic            capture,
    output logic            lsu_done,
    output logic            busy
);

    lsu_state_t            state;
    lsu_state_t            state_nxt;
    logic [XLEN-OFS_W-1:0] word_addr;
    logic                  is_store;
    logic                  in_beat;
    mem_size_t             size_nxt;
    logic                  split_nxt;

    // Split when the access runs past byte 3 of the word
    always_comb begin
        size_nxt = mem_size_t'(op.funct3[1:0]);
        case (size_nxt)
            HALF:    split_nxt = (op.result1[OFS_W-1:0] == 2'd3);
            WORD:    split_nxt = (op.result1[OFS_W-1:0] != 2'd0);
            default: split_nxt = 1'b0;
        endcase
    end

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (start) state_nxt = BEAT0;
            end
            BEAT0: begin
                if (data_gnt) state_nxt = req.split ? BEAT1 : DONE;
            end
            BEAT1: begin
                if (data_gnt) state_nxt = DONE;
            end
            // A new access may start right away
            DONE: begin
                state_nxt = start ? BEAT0 : IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            is_store <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) is_store <= op.st;
        end
    end

    // Access descriptor and word address
    always_ff @(posedge clk) begin
        if (start) begin
            word_addr       <= op.result1[XLEN-1:OFS_W];
            req.offset      <= op.result1[OFS_W-1:0];
            req.size        <= size_nxt;
            req.is_unsigned <= op.funct3[2];
            req.split       <= split_nxt;
        end else if (state == BEAT0 && data_gnt && req.split) begin
            // Step to the next word for the second beat
            word_addr <= word_addr + 1'b1;
        end
    end

    assign in_beat     = (state == BEAT0) || (state == BEAT1);
    assign data_addr   = {word_addr, {OFS_W{1'b0}}};
    assign data_rd_req = in_beat & ~is_store;
    assign data_wr_req = in_beat & is_store;
    assign beat_sel    = (state == BEAT1);
    assign capture     = data_rd_req & data_gnt;
    assign lsu_done    = (state == DONE);
    assign busy        = in_beat;

endmodule

//--- sources.f
wb_pkg.sv
lsu_ctrl.sv
load_align.sv
store_align.sv
wb_stage.sv
tb_data_mem.sv
tb_wb_stage.sv

//--- store_align.sv
// ==============================
// Store data rotation and per-beat byte mask
// ==============================

`timescale 1ns/100ps

module store_align
    import wb_pkg::*;
(
    input  lsu_req_t          req,
    input  logic              beat_sel,
    input  logic [XLEN-1:0]   store_data,
    output logic [XLEN-1:0]   data_wr_data,
    output logic [MASK_W-1:0] data_wr_mask
);

    logic [MASK_W-1:0]   size_mask;
    logic [2*XLEN-1:0]   data_pair;
    logic [2*MASK_W-1:0] mask_pair;

    // Bytes touched by the access before shifting
    always_comb begin
        case (req.size)
            BYTE:    size_mask = {{(MASK_W-1){1'b0}}, 1'b1};
            HALF:    size_mask = {{(MASK_W-2){1'b0}}, 2'b11};
            default: size_mask = '1;
        endcase
    end

    // Upper half only used by a split access
    always_comb begin
        data_pair = {{XLEN{1'b0}}, store_data} << {req.offset, 3'b000};
        mask_pair = {{MASK_W{1'b0}}, size_mask} << req.offset;
    end

    // ==============================
    // Beat select
    // ==============================
    always_comb begin
        if (beat_sel) begin
            data_wr_data = data_pair[2*XLEN-1:XLEN];
            data_wr_mask = mask_pair[2*MASK_W-1:MASK_W];
        end else begin
            data_wr_data = data_pair[XLEN-1:0];
            data_wr_mask = mask_pair[MASK_W-1:0];
        end
    end

endmodule

//--- tb_data_mem.sv
// ==============================
// Testbench word memory, LFSR-delayed grant and masked writes
// ==============================

`timescale 1ns/100ps

module tb_data_mem
    import wb_pkg::*;
#(
    parameter int          DEPTH = 64,
    parameter logic [31:0] SEED  = 32'h1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [XLEN-1:0]   addr,
    input  logic [XLEN-1:0]   wr_data,
    input  logic [MASK_W-1:0] wr_mask,
    input  logic              rd_req,
    input  logic              wr_req,
    output logic              gnt,
    output logic [XLEN-1:0]   rd_data
);

    logic [XLEN-1:0] mem [DEPTH];
    logic [31:0]     lfsr = SEED;
    logic            pending;
    logic [1:0]      count;
    logic [1:0]      delay;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int word_index(input logic [XLEN-1:0] a);
        return (a >> 2) % DEPTH;
    endfunction

    task fill_memory();
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = (i + 1) * 32'h9e3779b9;
        end
    endtask

    task write_word(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d);
        mem[word_index(a)] = d;
    endtask

    initial begin
        gnt     = 1'b0;
        rd_data = '0;
    end

    always @(posedge clk) begin
        if (reset) begin
            gnt     <= 1'b0;
            pending <= 1'b0;
            count   <= 2'd0;
        end else if (gnt) begin
            // Write lands on the grant edge
            gnt <= 1'b0;
            if (wr_req) begin
                for (int b = 0; b < MASK_W; b++) begin
                    if (wr_mask[b]) mem[word_index(addr)][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end else if (rd_req || wr_req) begin
            if (!pending) begin
                lfsr     = lfsr_step(lfsr);
                delay[0] = lfsr[0];
                lfsr     = lfsr_step(lfsr);
                delay[1] = lfsr[0];
                if (delay == 2'd0) begin
                    gnt     <= 1'b1;
                    rd_data <= mem[word_index(addr)];
                end else begin
                    pending <= 1'b1;
                    count   <= delay - 2'd1;
                end
            end else if (count == 2'd0) begin
                gnt     <= 1'b1;
                rd_data <= mem[word_index(addr)];
                pending <= 1'b0;
            end else begin
                count <= count - 2'd1;
            end
        end
    end

endmodule

//--- tb_wb_stage.sv
// ==============================
// Vector-driven write-back stage testbench
// ==============================

`timescale 1ns/100ps

module tb_wb_stage
    import wb_pkg::*;
();

    localparam int          CLK_PERIOD = 4;
    localparam int          MEM_DEPTH  = 64;
    localparam int          MAX_OPS    = 64;
    localparam int          WD_MARGIN  = 200;
    localparam logic [31:0] LFSR_SEED  = 32'h6851bdf4;

    logic                 clk = 1'b0;
    logic                 reset;
    pipe_exwb_t           execute;
    logic                 pipe_in_vld;
    logic                 pipe_in_rdy;
    logic [XLEN-1:0]      regwr_data;
    logic [REG_SEL_W-1:0] regwr_sel;
    logic                 regwr_en;
    logic [XLEN-1:0]      branch_target;
    logic                 branch;
    logic [XLEN-1:0]      data_addr;
    logic [XLEN-1:0]      data_rd_data;
    logic [XLEN-1:0]      data_wr_data;
    logic [MASK_W-1:0]    data_wr_mask;
    logic                 data_rd_req;
    logic                 data_wr_req;
    logic                 data_gnt;

    // Vectors and expected pulses
    logic [7:0]           kinds [MAX_OPS];
    pipe_exwb_t           ops [MAX_OPS];
    logic [XLEN-1:0]      exp0 [MAX_OPS];
    logic [XLEN-1:0]      exp1 [MAX_OPS];
    int                   n_ops = 0;
    logic [XLEN-1:0]      q_rd_data [$];
    logic [REG_SEL_W-1:0] q_rd_sel [$];
    int                   q_rd_cyc [$];
    logic [XLEN-1:0]      q_br [$];
    int                   q_br_cyc [$];
    int                   cycle_cnt = 0;
    int                   beats_left = 0;
    int                   acc_beats;
    logic                 accepting;
    logic                 cur_split = 1'b0;
    logic [XLEN-1:0]      first_addr;
    logic                 loaded;

    always #(CLK_PERIOD / 2) clk = ~clk;

    wb_stage DUT (.*);

    tb_data_mem #(.DEPTH(MEM_DEPTH), .SEED(LFSR_SEED)) u_mem (
        .clk(clk), .reset(reset), .addr(data_addr), .wr_data(data_wr_data),
        .wr_mask(data_wr_mask), .rd_req(data_rd_req), .wr_req(data_wr_req),
        .gnt(data_gnt), .rd_data(data_rd_data)
    );

    // ==============================
    // Failure reporting and compares
    // ==============================
    task fail_value(input string msg);
        $display("Fail at %0d ns: %s (lsu state %s)", $time, msg,
                 DUT.u_lsu_ctrl.state.name());
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task fail_plain(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task check_regwr(input logic [XLEN-1:0] exp_data, input logic [REG_SEL_W-1:0] exp_sel);
        if (regwr_data !== exp_data || regwr_sel !== exp_sel)
            fail_value($sformatf("register write x%0d=%h, expected x%0d=%h",
                                 regwr_sel, regwr_data, exp_sel, exp_data));
    endtask

    task check_branch(input logic [XLEN-1:0] exp_target);
        if (branch_target !== exp_target)
            fail_value($sformatf("branch target %h, expected %h", branch_target, exp_target));
    endtask

    task check_mem_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] exp_word);
        logic [XLEN-1:0] got;
        got = u_mem.mem[(addr >> 2) % MEM_DEPTH];
        if (got !== exp_word)
            fail_value($sformatf("memory word %h holds %h, expected %h", addr, got, exp_word));
    endtask

    // Half at offset 3 or unaligned word needs two beats
    function automatic logic crosses_word(input logic [2:0] f3, input logic [XLEN-1:0] a);
        case (f3[1:0])
            HALF:    return a[1:0] == 2'd3;
            WORD:    return a[1:0] != 2'd0;
            default: return 1'b0;
        endcase
    endfunction

    task read_vectors();
        int                   fd;
        int                   n;
        string                line;
        logic [7:0]           k;
        logic [2:0]           f3;
        logic [XLEN-1:0]      r1, r2, e0, e1;
        logic [REG_SEL_W-1:0] rd;
        fd = $fopen("wb_vectors.txt", "r");
        if (fd == 0) fail_plain("Cannot open wb_vectors.txt");
        u_mem.fill_memory();
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%s %h %h %h %h %h %h", k, f3, r1, r2, rd, e0, e1);
            if (n == 7 && k == "M") begin
                u_mem.write_word(r1, r2);
            end else if (n == 7) begin
                kinds[n_ops] = k;
                ops[n_ops]   = '{result1: r1, result2: r2, rd: rd,
                                 rd_write: (k == "A" || k == "J" || k == "L"),
                                 ld: (k == "L"), st: (k == "S"),
                                 branch: (k == "B" || k == "J"), funct3: f3};
                exp0[n_ops]  = e0;
                exp1[n_ops]  = e1;
                n_ops++;
            end
        end
        $fclose(fd);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    task run_op(input int i);
        pipe_exwb_t op;
        int         cyc;
        op          = ops[i];
        execute     = op;
        pipe_in_vld = 1'b1;
        while (!pipe_in_rdy) @(negedge clk);
        cyc = cycle_cnt + 1;
        case (kinds[i])
            "A", "L": begin
                q_rd_data.push_back(exp0[i]);
                q_rd_sel.push_back(op.rd);
                // Load cycle is known at its last grant
                q_rd_cyc.push_back(kinds[i] == "A" ? cyc : -1);
            end
            "B": begin
                q_br.push_back(exp0[i]);
                q_br_cyc.push_back(cyc);
            end
            "J": begin
                q_br.push_back(exp0[i]);
                q_br_cyc.push_back(cyc);
                q_rd_data.push_back(exp1[i]);
                q_rd_sel.push_back(op.rd);
                q_rd_cyc.push_back(cyc);
            end
            default: ;
        endcase
        acc_beats = (op.ld || op.st) ? (crosses_word(op.funct3, op.result1) ? 2 : 1) : 0;
        accepting = 1'b1;
        @(negedge clk);
        accepting   = 1'b0;
        pipe_in_vld = 1'b0;
        if (op.st) begin
            while (beats_left != 0) @(negedge clk);
            check_mem_word(op.result1 & ~32'h3, exp0[i]);
            check_mem_word((op.result1 & ~32'h3) + 4, exp1[i]);
        end
    endtask

    // Beats still owed by the operation in flight
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (reset) begin
            beats_left <= 0;
        end else if (accepting) begin
            beats_left <= acc_beats;
            cur_split  <= (acc_beats == 2);
        end else if (data_gnt && beats_left != 0) begin
            beats_left <= beats_left - 1;
            // A load writes back in the cycle after its last grant
            if (beats_left == 1 && data_rd_req && q_rd_cyc.size() != 0)
                q_rd_cyc[q_rd_cyc.size() - 1] = cycle_cnt + 1;
        end
    end

    // ==============================
    // Output monitor
    // ==============================
    always @(negedge clk) begin
        if (!reset && loaded) begin
            if (pipe_in_rdy !== (beats_left == 0))
                fail_value("pipe_in_rdy does not match the memory operation in flight");
            if ((data_rd_req || data_wr_req) && beats_left == 0)
                fail_value("memory request with no operation in flight");
            if (data_gnt && data_addr[1:0] !== 2'b00)
                fail_value("data_addr not word aligned");
            if (data_gnt && beats_left == 2)
                first_addr = data_addr;
            else if (data_gnt && cur_split && data_addr !== first_addr + 4)
                fail_value("second beat not at the next word");
            if (regwr_en && q_rd_data.size() == 0) begin
                fail_value("unexpected register write");
            end else if (regwr_en) begin
                if (q_rd_cyc[0] >= 0 && q_rd_cyc[0] != cycle_cnt)
                    fail_value("register write in the wrong cycle");
                check_regwr(q_rd_data.pop_front(), q_rd_sel.pop_front());
                void'(q_rd_cyc.pop_front());
            end else if (q_rd_cyc.size() != 0 && q_rd_cyc[0] >= 0 && q_rd_cyc[0] <= cycle_cnt) begin
                fail_value("missing register write");
            end
            if (branch && q_br.size() == 0) begin
                fail_value("unexpected branch pulse");
            end else if (branch) begin
                if (q_br_cyc.pop_front() != cycle_cnt)
                    fail_value("branch pulse in the wrong cycle");
                check_branch(q_br.pop_front());
            end else if (q_br_cyc.size() != 0 && q_br_cyc[0] <= cycle_cnt) begin
                fail_value("missing branch pulse");
            end
        end
    end

    initial begin
        reset       = 1'b1;
        pipe_in_vld = 1'b0;
        execute     = '0;
        accepting   = 1'b0;
        acc_beats   = 0;
        loaded      = 1'b0;
        read_vectors();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (regwr_en || branch || data_rd_req || data_wr_req || DUT.lsu_done || !pipe_in_rdy)
            fail_plain("Outputs are not idle after reset");
        reset = 1'b0;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        repeat (6) @(negedge clk);
        if (q_rd_data.size() == 0 && q_br.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Expected write-back pulses never arrived");
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        #((n_ops * 20 + WD_MARGIN) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in time");
        $display("Result: FAILED");
        $fatal(1);
    end

endmodule

//--- wb_pkg.sv
// ==============================
// Write-back stage types, enums and width constants
// ==============================

package wb_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int XLEN      = 32;
    localparam int REG_SEL_W = 5;
    localparam int MASK_W    = XLEN / 8;
    // Byte offset within a word
    localparam int OFS_W     = 2;

    // Low two bits of funct3
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_t;

    // ==============================
    // Execute to write-back
    // ==============================
    typedef struct packed {
        // Memory address or ALU value
        logic [XLEN-1:0]      result1;
        // Store data or branch target
        logic [XLEN-1:0]      result2;
        logic [REG_SEL_W-1:0] rd;
        logic                 rd_write;
        logic                 ld;
        logic                 st;
        logic                 branch;
        // Unsigned flag on top of a mem_size_t
        logic [2:0]           funct3;
    } pipe_exwb_t;

    // Access descriptor shared by both aligners
    typedef struct packed {
        logic [OFS_W-1:0] offset;
        mem_size_t        size;
        logic             is_unsigned;
        // Access crosses into the next word
        logic             split;
    } lsu_req_t;

    // Memory access FSM
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        BEAT0 = 2'b01,
        BEAT1 = 2'b10,
        DONE  = 2'b11
    } lsu_state_t;

endpackage

//--- wb_stage.sv
// ==============================
// Write-back stage top, handshake and register-write mux
// ==============================

`timescale 1ns/100ps

module wb_stage
    import wb_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  pipe_exwb_t           execute,
    input  logic                 pipe_in_vld,
    output logic                 pipe_in_rdy,
    output logic [XLEN-1:0]      regwr_data,
    output logic [REG_SEL_W-1:0] regwr_sel,
    output logic                 regwr_en,
    output logic [XLEN-1:0]      branch_target,
    output logic                 branch,
    output logic [XLEN-1:0]      data_addr,
    input  logic [XLEN-1:0]      data_rd_data,
    output logic [XLEN-1:0]      data_wr_data,
    output logic [MASK_W-1:0]    data_wr_mask,
    output logic                 data_rd_req,
    output logic                 data_wr_req,
    input  logic                 data_gnt
);

    logic                 accept;
    logic                 mem_start;
    logic                 busy;
    logic                 lsu_done;
    logic                 beat_sel;
    logic                 capture;
    lsu_req_t             lsu_req;
    logic [XLEN-1:0]      load_data;
    logic [XLEN-1:0]      store_data;
    logic                 alu_wr;
    logic [XLEN-1:0]      alu_data;
    logic [REG_SEL_W-1:0] alu_sel;
    logic                 ld_wr;
    logic [REG_SEL_W-1:0] ld_sel;
    logic                 ld_commit;

    assign pipe_in_rdy = ~busy;
    assign accept      = pipe_in_vld & pipe_in_rdy;
    assign mem_start   = accept & (execute.ld | execute.st);

    // ==============================
    // ALU and branch results
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            alu_wr <= 1'b0;
            branch <= 1'b0;
            ld_wr  <= 1'b0;
        end else begin
            alu_wr <= accept & execute.rd_write & ~execute.ld & ~execute.st;
            branch <= accept & execute.branch;
            if (mem_start) ld_wr <= execute.ld & execute.rd_write;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_data      <= execute.result1;
            alu_sel       <= execute.rd;
            branch_target <= execute.result2;
        end
        // Held until the memory access completes
        if (mem_start) begin
            ld_sel     <= execute.rd;
            store_data <= execute.result2;
        end
    end

    // Register-write mux
    assign ld_commit  = lsu_done & ld_wr;
    assign regwr_en   = alu_wr | ld_commit;
    assign regwr_data = ld_commit ? load_data : alu_data;
    assign regwr_sel  = ld_commit ? ld_sel : alu_sel;

    // ==============================
    // Memory access blocks
    // ==============================
    lsu_ctrl u_lsu_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (mem_start),
        .op         (execute),
        .data_gnt   (data_gnt),
        .req        (lsu_req),
        .data_addr  (data_addr),
        .data_rd_req(data_rd_req),
        .data_wr_req(data_wr_req),
        .beat_sel   (beat_sel),
        .capture    (capture),
        .lsu_done   (lsu_done),
        .busy       (busy)
    );

    load_align u_load_align (
        .clk         (clk),
        .reset       (reset),
        .req         (lsu_req),
        .capture     (capture),
        .beat_sel    (beat_sel),
        .data_rd_data(data_rd_data),
        .load_data   (load_data)
    );

    store_align u_store_align (
        .req         (lsu_req),
        .beat_sel    (beat_sel),
        .store_data  (store_data),
        .data_wr_data(data_wr_data),
        .data_wr_mask(data_wr_mask)
    );

endmodule

//--- wb_vectors.txt
# kind funct3 result1 result2 rd exp0 exp1   (all hex)
# M: addr data. A: exp0 = rd value. B: exp0 = target. J: exp0 target, exp1 rd value
# L: exp0 = rd value. S: exp0/exp1 = addressed word and the word after it
M 0 00000000 88776655 0 0 0
M 0 00000004 f0e1d2c3 0 0 0
M 0 00000008 12345678 0 0 0
M 0 0000000c a0b0c0d0 0 0 0
M 0 00000010 00000000 0 0 0
M 0 00000014 00000000 0 0 0
M 0 00000018 11111111 0 0 0
M 0 0000001c 22222222 0 0 0
M 0 00000020 33333333 0 0 0
A 0 12345678 00000000 01 12345678 0
A 0 deadbeef 00000000 02 deadbeef 0
A 0 00000000 00000000 03 00000000 0
A 0 ffffffff 00000000 1f ffffffff 0
B 0 00000000 80000010 00 80000010 0
J 0 00000104 00000200 01 00000200 00000104
A 0 0000abcd 00000000 04 0000abcd 0
L 0 00000003 00000000 05 ffffff88 0
L 4 00000003 00000000 06 00000088 0
L 0 00000000 00000000 07 00000055 0
L 1 00000006 00000000 08 fffff0e1 0
L 5 00000006 00000000 09 0000f0e1 0
L 2 00000008 00000000 0a 12345678 0
L 0 0000000d 00000000 10 ffffffc0 0
L 5 00000001 00000000 11 00007766 0
L 5 00000007 00000000 0b 000078f0 0
L 5 00000003 00000000 0c 0000c388 0
L 1 0000000b 00000000 12 ffffd012 0
L 2 00000005 00000000 0d 78f0e1d2 0
L 2 0000000e 00000000 0e 0000a0b0 0
A 0 00000055 00000000 13 00000055 0
S 0 00000011 deadbeef 00 0000ef00 00000000
S 1 00000012 cafebabe 00 babeef00 00000000
S 2 00000014 01020304 00 01020304 11111111
S 1 00000017 0000aabb 00 bb020304 111111aa
S 2 0000001a 55667788 00 778811aa 22225566
S 0 0000001f 000000ff 00 ff225566 33333333
L 2 00000019 00000000 0f 66778811 0
B 0 00000000 00000040 00 00000040 0
A 0 87654321 00000000 14 87654321 0
